// ==== rtl/fetch_macros.svh ====
////////////////////////////////////////
// fetch buffer widths and limits
////////////////////////////////////////
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// bus address and read word widths
`define FETCH_ADDR_W 32
`define FETCH_DATA_W 32
// default fifo depth in bus words
`define FETCH_FIFO_DEPTH 4
// granted reads allowed without a response
`define FETCH_MAX_OUTSTANDING 2

`endif

// ==== rtl/fetch_mem_pkg.sv ====
////////////////////////////////////////
// memory side types of the fetch buffer
////////////////////////////////////////

`include "fetch_macros.svh"

package fetch_mem_pkg;

  // byte address on the instruction bus
  typedef logic [`FETCH_ADDR_W-1:0] mem_addr_t;

  // one read word as returned with rvalid
  typedef logic [`FETCH_DATA_W-1:0] mem_word_t;

endpackage

// ==== rtl/fetch_instr_pkg.sv ====
////////////////////////////////////////
// instruction side types of the fetch buffer
////////////////////////////////////////

`include "fetch_macros.svh"

package fetch_instr_pkg;

  // aligned instruction, compressed ones in the low half
  typedef logic [`FETCH_DATA_W-1:0] instr_t;

  // fifo fill count, holds 0 up to the depth
  typedef logic [$clog2(`FETCH_FIFO_DEPTH + 1)-1:0] fill_cnt_t;

  // request fsm of the prefetch controller
  typedef enum logic [1:0] {
    PF_IDLE     = 2'b00,
    PF_REQ      = 2'b01,
    PF_WAIT_GNT = 2'b10
  } pf_state_t;

endpackage

// ==== rtl/fetch_fifo.sv ====
////////////////////////////////////////
// fetch fifo, buffers bus words and aligns
// compressed and 32-bit instructions
////////////////////////////////////////

`timescale 1ns/1ps

`include "fetch_macros.svh"

module fetch_fifo #(
  parameter int unsigned DEPTH = `FETCH_FIFO_DEPTH
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // branch clears the fifo on the next edge
  input  logic                       branch_i,
  input  fetch_mem_pkg::mem_addr_t   branch_addr_i,
  // words from the prefetch controller
  input  logic                       in_valid_i,
  input  fetch_mem_pkg::mem_word_t   in_rdata_i,
  output fetch_instr_pkg::fill_cnt_t in_cnt_o,
  // aligned instructions to decode
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output fetch_instr_pkg::instr_t    out_rdata_o,
  output fetch_mem_pkg::mem_addr_t   out_addr_o
);

  // entry 0 is the head word
  fetch_mem_pkg::mem_word_t   rdata_q   [DEPTH];
  fetch_mem_pkg::mem_word_t   rdata_int [DEPTH];
  fetch_mem_pkg::mem_word_t   rdata_n   [DEPTH];
  logic [DEPTH-1:0]           valid_q;
  logic [DEPTH-1:0]           valid_int;
  logic [DEPTH-1:0]           valid_n;
  fetch_mem_pkg::mem_addr_t   addr_q;
  fetch_mem_pkg::mem_addr_t   addr_n;
  fetch_mem_pkg::mem_addr_t   addr_incr;
  fetch_mem_pkg::mem_word_t   head_word;
  fetch_mem_pkg::mem_word_t   unal_word;
  fetch_mem_pkg::mem_word_t   sel_word;
  logic                       head_valid;
  logic                       unal_valid;
  logic                       head_cmp;
  logic                       unal_cmp;
  logic                       is_cmp;
  logic                       pop;
  logic                       slot_found;
  fetch_instr_pkg::fill_cnt_t cnt;

  ////////////////////////////////////////
  // aligner
  ////////////////////////////////////////

  // empty fifo passes the incoming word straight through
  assign head_word  = valid_q[0] ? rdata_q[0] : in_rdata_i;
  assign head_valid = valid_q[0] | in_valid_i;

  // upper half of head plus lower half of the next word
  assign unal_word  = {(valid_q[1] ? rdata_q[1][15:0] : in_rdata_i[15:0]),
                       head_word[31:16]};
  // second half present only if head is already stored
  assign unal_valid = valid_q[1] | (valid_q[0] & in_valid_i);

  // low two bits not both set means 16-bit instruction
  assign head_cmp = head_word[1:0] != 2'b11;
  assign unal_cmp = head_word[17:16] != 2'b11;

  assign is_cmp   = addr_q[1] ? unal_cmp : head_cmp;
  assign sel_word = addr_q[1] ? unal_word : head_word;

  always_comb begin
    if (addr_q[1]) begin
      // a 32-bit instruction at pc+2 waits for its second word
      out_valid_o = head_valid & (unal_cmp | unal_valid);
    end else begin
      out_valid_o = head_valid;
    end
  end

  // compressed instructions come out zero extended
  assign out_rdata_o = is_cmp ? {16'h0000, sel_word[15:0]} : sel_word;
  assign out_addr_o  = addr_q;

  assign pop = out_valid_o & out_ready_i;

  ////////////////////////////////////////
  // fill count and write
  ////////////////////////////////////////

  // valid bits stay packed from entry 0 upward
  always_comb begin
    cnt = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (valid_q[i]) begin
        cnt = fetch_instr_pkg::fill_cnt_t'(i + 1);
      end
    end
  end

  // reads as empty during a branch so the controller restarts at once
  assign in_cnt_o = branch_i ? '0 : cnt;

  // new word goes into the first free entry
  always_comb begin
    rdata_int  = rdata_q;
    valid_int  = valid_q;
    slot_found = 1'b0;
    for (int j = 0; j < DEPTH; j++) begin
      if (in_valid_i && !slot_found && !valid_q[j]) begin
        rdata_int[j] = in_rdata_i;
        valid_int[j] = 1'b1;
        slot_found   = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // pc advance and shift
  ////////////////////////////////////////

  assign addr_incr = {addr_q[`FETCH_ADDR_W-1:2], 2'b00} + 4;

  always_comb begin
    addr_n  = addr_q;
    rdata_n = rdata_int;
    valid_n = valid_int;
    if (pop) begin
      if (!addr_q[1] && head_cmp) begin
        // second half of the head word is still to be used
        addr_n = {addr_q[`FETCH_ADDR_W-1:2], 2'b10};
      end else begin
        // head word spent
        if (addr_q[1] && !unal_cmp) begin
          addr_n = {addr_incr[`FETCH_ADDR_W-1:2], 2'b10};
        end else begin
          addr_n = addr_incr;
        end
        for (int k = 0; k < DEPTH - 1; k++) begin
          rdata_n[k] = rdata_int[k + 1];
        end
        valid_n = valid_int >> 1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      addr_q  <= '0;
    end else if (branch_i) begin
      // target pc belongs to the first word after the flush
      valid_q <= '0;
      addr_q  <= branch_addr_i;
    end else begin
      valid_q <= valid_n;
      addr_q  <= addr_n;
    end
  end

  always_ff @(posedge clk) begin
    rdata_q <= rdata_n;
  end

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  // controller must never deliver into a full fifo
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    in_valid_i |-> !valid_q[DEPTH-1]);

  a_flush_empty : assert property (@(posedge clk) disable iff (!rst_n)
    branch_i |=> (valid_q == '0));

  // the controller sees zero while a branch restarts fetch
  a_branch_cnt : assert property (@(posedge clk) disable iff (!rst_n)
    branch_i |-> (in_cnt_o == '0));

endmodule

// ==== rtl/prefetch_ctrl.sv ====
////////////////////////////////////////
// prefetch controller, issues word reads and
// drops responses that belong to an old path
////////////////////////////////////////

`timescale 1ns/1ps

`include "fetch_macros.svh"

module prefetch_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       enable_i,
  input  logic                       branch_i,
  input  fetch_mem_pkg::mem_addr_t   branch_addr_i,
  input  fetch_instr_pkg::fill_cnt_t fifo_cnt_i,
  // instruction memory bus
  output logic                       instr_req_o,
  output fetch_mem_pkg::mem_addr_t   instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic                       instr_rvalid_i,
  input  fetch_mem_pkg::mem_word_t   instr_rdata_i,
  // filtered responses to the fifo
  output logic                       fifo_valid_o,
  output fetch_mem_pkg::mem_word_t   fifo_rdata_o
);

  localparam int unsigned OUTS_W = $clog2(`FETCH_MAX_OUTSTANDING + 1);

  fetch_instr_pkg::pf_state_t state_q;
  fetch_instr_pkg::pf_state_t state_n;
  fetch_mem_pkg::mem_addr_t   addr_q;
  logic [OUTS_W-1:0]          outs_q;
  logic [OUTS_W-1:0]          outs_n;
  logic [OUTS_W-1:0]          discard_q;
  logic [OUTS_W-1:0]          discard_n;
  logic                       can_issue;
  logic                       gnt_ok;
  logic                       rsp_stale;

  // buffer room counts words in flight as taken
  assign can_issue = enable_i
                   && (outs_q < `FETCH_MAX_OUTSTANDING)
                   && (int'(fifo_cnt_i) + int'(outs_q) < `FETCH_FIFO_DEPTH);

  ////////////////////////////////////////
  // request fsm
  ////////////////////////////////////////

  always_comb begin
    state_n     = state_q;
    instr_req_o = 1'b0;
    unique case (state_q)
      fetch_instr_pkg::PF_IDLE: begin
        if (enable_i) begin
          state_n = fetch_instr_pkg::PF_REQ;
        end
      end
      fetch_instr_pkg::PF_REQ: begin
        // nothing goes out in the branch cycle, the address is stale
        instr_req_o = can_issue && !branch_i;
        if (instr_req_o && !instr_gnt_i) begin
          state_n = fetch_instr_pkg::PF_WAIT_GNT;
        end else if (!enable_i) begin
          state_n = fetch_instr_pkg::PF_IDLE;
        end
      end
      fetch_instr_pkg::PF_WAIT_GNT: begin
        // hold until granted, a branch withdraws it
        instr_req_o = !branch_i;
        if (branch_i || instr_gnt_i) begin
          state_n = enable_i ? fetch_instr_pkg::PF_REQ : fetch_instr_pkg::PF_IDLE;
        end
      end
      default: begin
        state_n = fetch_instr_pkg::PF_IDLE;
      end
    endcase
  end

  assign gnt_ok       = instr_req_o & instr_gnt_i;
  assign instr_addr_o = addr_q;

  ////////////////////////////////////////
  // outstanding and discard counters
  ////////////////////////////////////////

  always_comb begin
    outs_n = outs_q;
    if (gnt_ok && !instr_rvalid_i) begin
      outs_n = outs_q + OUTS_W'(1);
    end else if (!gnt_ok && instr_rvalid_i) begin
      outs_n = outs_q - OUTS_W'(1);
    end
  end

  // every read in flight at a branch is old path data
  always_comb begin
    discard_n = discard_q;
    if (branch_i) begin
      discard_n = instr_rvalid_i ? outs_q - OUTS_W'(1) : outs_q;
    end else if (instr_rvalid_i && discard_q != '0) begin
      discard_n = discard_q - OUTS_W'(1);
    end
  end

  assign rsp_stale    = instr_rvalid_i & (branch_i | (discard_q != '0));
  assign fifo_valid_o = instr_rvalid_i & ~rsp_stale;
  assign fifo_rdata_o = instr_rdata_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= fetch_instr_pkg::PF_IDLE;
      addr_q    <= '0;
      outs_q    <= '0;
      discard_q <= '0;
    end else begin
      state_q   <= state_n;
      outs_q    <= outs_n;
      discard_q <= discard_n;
      if (branch_i) begin
        // restart on the word holding the target
        addr_q <= {branch_addr_i[`FETCH_ADDR_W-1:2], 2'b00};
      end else if (gnt_ok) begin
        addr_q <= addr_q + 4;
      end
    end
  end

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  a_addr_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i) |=>
      (branch_i || (instr_req_o && $stable(instr_addr_o))));

  // memory answers only reads it has granted
  a_rvalid_owed : assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> (outs_q != '0));

endmodule

// ==== rtl/fetch_cfg_regs.sv ====
////////////////////////////////////////
// fetch enable and boot address registers
// with boot kick-off and branch merge
////////////////////////////////////////

`timescale 1ns/1ps

`include "fetch_macros.svh"

module fetch_cfg_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  // register write port
  input  logic                     cfg_we_i,
  input  logic                     cfg_sel_i,
  input  fetch_mem_pkg::mem_word_t cfg_wdata_i,
  // branch from the core
  input  logic                     core_branch_i,
  input  fetch_mem_pkg::mem_addr_t core_branch_addr_i,
  output logic                     enable_o,
  output logic                     branch_o,
  output fetch_mem_pkg::mem_addr_t branch_addr_o
);

  logic                     enable_q;
  logic                     enable_prev_q;
  logic                     kick_q;
  fetch_mem_pkg::mem_addr_t boot_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enable_q      <= 1'b0;
      enable_prev_q <= 1'b0;
      kick_q        <= 1'b0;
      boot_addr_q   <= '0;
    end else begin
      // sel 0 is enable, sel 1 is boot address
      if (cfg_we_i && !cfg_sel_i) begin
        enable_q <= cfg_wdata_i[0];
      end
      if (cfg_we_i && cfg_sel_i) begin
        boot_addr_q <= fetch_mem_pkg::mem_addr_t'(cfg_wdata_i);
      end
      enable_prev_q <= enable_q;
      // one pulse the cycle after enable goes 0 to 1
      kick_q        <= enable_q & ~enable_prev_q;
    end
  end

  assign enable_o      = enable_q;
  // core branch wins over the kick-off
  assign branch_o      = core_branch_i | kick_q;
  assign branch_addr_o = core_branch_i ? core_branch_addr_i : boot_addr_q;

  a_kick_single : assert property (@(posedge clk) disable iff (!rst_n)
    kick_q |=> !kick_q);

endmodule

// ==== rtl/prefetch_buffer.sv ====
////////////////////////////////////////
// instruction prefetch buffer top level
////////////////////////////////////////

`timescale 1ns/1ps

`include "fetch_macros.svh"

module prefetch_buffer (
  input  logic                     clk,
  input  logic                     rst_n,
  // configuration writes
  input  logic                     cfg_we_i,
  input  logic                     cfg_sel_i,
  input  fetch_mem_pkg::mem_word_t cfg_wdata_i,
  // branch from the core
  input  logic                     core_branch_i,
  input  fetch_mem_pkg::mem_addr_t core_branch_addr_i,
  // instruction memory bus
  output logic                     instr_req_o,
  output fetch_mem_pkg::mem_addr_t instr_addr_o,
  input  logic                     instr_gnt_i,
  input  logic                     instr_rvalid_i,
  input  fetch_mem_pkg::mem_word_t instr_rdata_i,
  // decode side
  input  logic                     out_ready_i,
  output logic                     out_valid_o,
  output fetch_instr_pkg::instr_t  out_rdata_o,
  output fetch_mem_pkg::mem_addr_t out_addr_o
);

  logic                       enable;
  logic                       branch;
  fetch_mem_pkg::mem_addr_t   branch_addr;
  logic                       fifo_valid;
  fetch_mem_pkg::mem_word_t   fifo_rdata;
  fetch_instr_pkg::fill_cnt_t fifo_cnt;

  fetch_cfg_regs i_cfg_regs (
    .clk               (clk),
    .rst_n             (rst_n),
    .cfg_we_i          (cfg_we_i),
    .cfg_sel_i         (cfg_sel_i),
    .cfg_wdata_i       (cfg_wdata_i),
    .core_branch_i     (core_branch_i),
    .core_branch_addr_i(core_branch_addr_i),
    .enable_o          (enable),
    .branch_o          (branch),
    .branch_addr_o     (branch_addr)
  );

  prefetch_ctrl i_prefetch_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable_i      (enable),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .fifo_cnt_i    (fifo_cnt),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i),
    .fifo_valid_o  (fifo_valid),
    .fifo_rdata_o  (fifo_rdata)
  );

  // same branch reaches controller and fifo in the same cycle
  fetch_fifo #(
    .DEPTH(`FETCH_FIFO_DEPTH)
  ) i_fetch_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .branch_i     (branch),
    .branch_addr_i(branch_addr),
    .in_valid_i   (fifo_valid),
    .in_rdata_i   (fifo_rdata),
    .in_cnt_o     (fifo_cnt),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_rdata_o  (out_rdata_o),
    .out_addr_o   (out_addr_o)
  );

endmodule

// ==== verification/tb_fetch_mem.sv ====
////////////////////////////////////////
// instruction memory model, random grant
// latency and in-order responses
////////////////////////////////////////

`timescale 1ns/1ps

module tb_fetch_mem (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_i,
  input  fetch_mem_pkg::mem_addr_t addr_i,
  output logic                     gnt_o,
  output logic                     rvalid_o,
  output fetch_mem_pkg::mem_word_t rdata_o
);

  // program image keyed by word address
  fetch_mem_pkg::mem_word_t image [fetch_mem_pkg::mem_addr_t];
  fetch_mem_pkg::mem_word_t rsp_data [$];
  int                       rsp_due [$];
  int                       cyc;
  int                       stall;
  int                       last_due;
  int                       due;

  // words outside the image hold 32-bit opcodes built from the address
  function automatic fetch_mem_pkg::mem_word_t read_word(input fetch_mem_pkg::mem_addr_t a);
    fetch_mem_pkg::mem_addr_t wa;
    wa = {a[31:2], 2'b00};
    if (image.exists(wa)) begin
      return image[wa];
    end
    return (wa * 32'h9e37_79b1) | 32'h0003_0003;
  endfunction

  initial begin
    int                       fd;
    int                       n;
    string                    line;
    fetch_mem_pkg::mem_addr_t a;
    fetch_mem_pkg::mem_word_t d;
    void'($urandom(32'h8a5b));
    fd = $fopen("verification/fetch_input.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        // only the mem lines belong to the image
        if (n > 0 && $sscanf(line, "mem %h %h", a, d) == 2) begin
          image[a] = d;
        end
      end
      $fclose(fd);
    end
  end

  ////////////////////////////////////////
  // sample the bus on the rising edge
  ////////////////////////////////////////
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc      = 0;
      stall    = 0;
      last_due = 0;
      rsp_data.delete();
      rsp_due.delete();
    end else begin
      cyc++;
      // a response shown this cycle is taken at this edge
      if (rvalid_o) begin
        void'(rsp_data.pop_front());
        void'(rsp_due.pop_front());
      end
      if (req_i && gnt_o) begin
        // due now means rvalid in the very next cycle
        due = cyc + $urandom_range(1, 0);
        // keep responses in grant order
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rsp_data.push_back(read_word(addr_i));
        rsp_due.push_back(due);
        stall = $urandom_range(2, 0);
      end else if (req_i && stall > 0) begin
        stall--;
      end
    end
  end

  // outputs change on the falling edge only
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      gnt_o    <= (stall == 0);
      rvalid_o <= (rsp_due.size() > 0) && (rsp_due[0] <= cyc);
      rdata_o  <= (rsp_data.size() > 0) ? rsp_data[0] : '0;
    end
  end

endmodule

// ==== verification/tb_prefetch_buffer.sv ====
////////////////////////////////////////
// testbench for the prefetch buffer
////////////////////////////////////////

`timescale 1ns/1ps

module tb_prefetch_buffer;

  // grant 2 + response 2 + one fifo cycle
  localparam int MEM_WORST = 5;

  logic                     clk;
  logic                     rst_n;
  logic                     cfg_we_i;
  logic                     cfg_sel_i;
  fetch_mem_pkg::mem_word_t cfg_wdata_i;
  logic                     core_branch_i;
  fetch_mem_pkg::mem_addr_t core_branch_addr_i;
  logic                     instr_req_o;
  fetch_mem_pkg::mem_addr_t instr_addr_o;
  logic                     instr_gnt_i;
  logic                     instr_rvalid_i;
  fetch_mem_pkg::mem_word_t instr_rdata_i;
  logic                     out_ready_i;
  logic                     out_valid_o;
  fetch_instr_pkg::instr_t  out_rdata_o;
  fetch_mem_pkg::mem_addr_t out_addr_o;

  // tests from the data file
  string                    tname [16];
  fetch_mem_pkg::mem_addr_t boot [16];
  int                       ready_pct [16];
  int                       br_cycle [16];
  fetch_mem_pkg::mem_addr_t br_target [16];
  int                       stop_en [16];
  int                       exp_first [16];
  int                       exp_cnt [16];
  fetch_mem_pkg::mem_addr_t exp_pc [256];
  fetch_instr_pkg::instr_t  exp_instr [256];
  int                       ntests;
  int                       nexp_total;
  int                       errors;
  int                       checks;
  int                       failed_tests;
  int                       wait_cycles;
  int                       limit;
  int                       cur_test;
  fetch_mem_pkg::mem_addr_t req_exp_addr;

  prefetch_buffer uut (
    .clk               (clk),
    .rst_n             (rst_n),
    .cfg_we_i          (cfg_we_i),
    .cfg_sel_i         (cfg_sel_i),
    .cfg_wdata_i       (cfg_wdata_i),
    .core_branch_i     (core_branch_i),
    .core_branch_addr_i(core_branch_addr_i),
    .instr_req_o       (instr_req_o),
    .instr_addr_o      (instr_addr_o),
    .instr_gnt_i       (instr_gnt_i),
    .instr_rvalid_i    (instr_rvalid_i),
    .instr_rdata_i     (instr_rdata_i),
    .out_ready_i       (out_ready_i),
    .out_valid_o       (out_valid_o),
    .out_rdata_o       (out_rdata_o),
    .out_addr_o        (out_addr_o)
  );

  tb_fetch_mem i_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_i   (instr_req_o),
    .addr_i  (instr_addr_o),
    .gnt_o   (instr_gnt_i),
    .rvalid_o(instr_rvalid_i),
    .rdata_o (instr_rdata_i)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic check_instr(input string name, input fetch_instr_pkg::instr_t exp,
                             input fetch_instr_pkg::instr_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch %s: instr expected %08h actual %08h", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input fetch_mem_pkg::mem_addr_t exp,
                            input fetch_mem_pkg::mem_addr_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch %s: pc expected %08h actual %08h", name, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // request address monitor
  ////////////////////////////////////////
  // granted reads step one word at a time from the boot or branch target
  always @(posedge clk) begin
    if (rst_n) begin
      if (instr_req_o && instr_gnt_i) begin
        check_addr({tname[cur_test], " req"}, req_exp_addr, instr_addr_o);
        req_exp_addr = req_exp_addr + 4;
      end
      if (core_branch_i) begin
        req_exp_addr = {core_branch_addr_i[31:2], 2'b00};
      end
    end
  end

  task automatic load_tests();
    int                       fd;
    int                       n;
    string                    line;
    string                    kw;
    string                    nm;
    fetch_mem_pkg::mem_addr_t a;
    fetch_mem_pkg::mem_addr_t t;
    fetch_instr_pkg::instr_t  ins;
    int                       rp;
    int                       bc;
    int                       st;
    fd = $fopen("verification/fetch_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file");
      $display("TB FAILED");
      $finish;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && $sscanf(line, "%s", kw) == 1) begin
        if (kw == "test"
            && $sscanf(line, "test %s %h %d %d %h %d", nm, a, rp, bc, t, st) == 6) begin
          tname[ntests]     = nm;
          boot[ntests]      = a;
          ready_pct[ntests] = rp;
          br_cycle[ntests]  = bc;
          br_target[ntests] = t;
          stop_en[ntests]   = st;
          exp_first[ntests] = nexp_total;
          exp_cnt[ntests]   = 0;
          ntests++;
        end else if (kw == "exp" && ntests > 0 && $sscanf(line, "exp %h %h", a, ins) == 2) begin
          exp_pc[nexp_total]    = a;
          exp_instr[nexp_total] = ins;
          exp_cnt[ntests-1]++;
          nexp_total++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_reset();
    rst_n         = 1'b0;
    cfg_we_i      = 1'b0;
    core_branch_i = 1'b0;
    out_ready_i   = 1'b1;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // called at a falling edge, returns at the next one
  task automatic cfg_write(input logic sel, input fetch_mem_pkg::mem_word_t data);
    cfg_we_i    = 1'b1;
    cfg_sel_i   = sel;
    cfg_wdata_i = data;
    @(negedge clk);
    cfg_we_i = 1'b0;
  endtask

  task automatic run_test(input int t);
    int idx;
    int cyc;
    int errs_before;
    bit br_done;
    errs_before        = errors;
    core_branch_addr_i = br_target[t];
    cur_test           = t;
    req_exp_addr       = {boot[t][31:2], 2'b00};
    apply_reset();
    cfg_write(1'b1, boot[t]);
    cfg_write(1'b0, 32'h1);
    idx     = exp_first[t];
    cyc     = 0;
    br_done = (br_cycle[t] == 0);
    while (idx < exp_first[t] + exp_cnt[t]) begin
      @(posedge clk);
      wait_cycles++;
      // anything taken at or before the branch edge is old path
      if (out_valid_o && out_ready_i && br_done) begin
        check_addr(tname[t], exp_pc[idx], out_addr_o);
        check_instr(tname[t], exp_instr[idx], out_rdata_o);
        idx++;
      end
      if (core_branch_i) begin
        br_done = 1'b1;
      end
      if (wait_cycles > limit) begin
        $display("timeout in test %s: got %0d of %0d instructions", tname[t],
                 idx - exp_first[t], exp_cnt[t]);
        $display("TB FAILED");
        $finish;
      end
      @(negedge clk);
      cyc++;
      core_branch_i = (cyc == br_cycle[t]);
      out_ready_i   = ($urandom_range(99, 0) < ready_pct[t]);
    end
    if (stop_en[t] != 0) begin
      core_branch_i = 1'b0;
      out_ready_i   = 1'b1;
      cfg_write(1'b0, 32'h0);
      // outstanding reads and buffered words drain here
      repeat (16) @(negedge clk);
      repeat (20) begin
        @(posedge clk);
        checks++;
        if (instr_req_o || out_valid_o) begin
          errors++;
          $display("test %s: request or instruction seen after fetch was disabled", tname[t]);
        end
      end
      @(negedge clk);
    end
    if (errors == errs_before) begin
      $display("test %s: ok", tname[t]);
    end else begin
      failed_tests++;
      $display("test %s: failed with %0d errors", tname[t], errors - errs_before);
    end
  endtask

  initial begin
    clk                = 1'b0;
    rst_n              = 1'b0;
    cfg_we_i           = 1'b0;
    cfg_sel_i          = 1'b0;
    cfg_wdata_i        = '0;
    core_branch_i      = 1'b0;
    core_branch_addr_i = '0;
    out_ready_i        = 1'b1;
    ntests             = 0;
    nexp_total         = 0;
    errors             = 0;
    checks             = 0;
    failed_tests       = 0;
    wait_cycles        = 0;
    cur_test           = 0;
    req_exp_addr       = '0;
    load_tests();
    limit = 4 * nexp_total * MEM_WORST + 200;
    for (int t = 0; t < ntests; t++) begin
      run_test(t);
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             ntests, failed_tests, checks, errors);
    if (errors == 0 && ntests > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/fetch_mem_pkg.sv
rtl/fetch_instr_pkg.sv
rtl/fetch_fifo.sv
rtl/prefetch_ctrl.sv
rtl/fetch_cfg_regs.sv
rtl/prefetch_buffer.sv
verification/tb_fetch_mem.sv
verification/tb_prefetch_buffer.sv

// ==== Bender.yml ====
package:
  name: prefetch_buffer

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fetch_mem_pkg.sv
      - rtl/fetch_instr_pkg.sv
      - rtl/fetch_fifo.sv
      - rtl/prefetch_ctrl.sv
      - rtl/fetch_cfg_regs.sv
      - rtl/prefetch_buffer.sv
  - target: simulation
    files:
      - verification/tb_fetch_mem.sv
      - verification/tb_prefetch_buffer.sv

// ==== verification/fetch_input.txt ====
# mem <word address> <word>   program image
# test <name> <boot> <ready %> <branch cycle, 0 none> <branch target> <stop>
# exp <pc> <instr>            expected stream, compressed zero extended
mem 00000100 00500093
mem 00000104 00a00113
mem 00000108 002081b3
mem 0000010c 40110233
mem 00000200 05054501
mem 00000204 00c58633
mem 00000208 01138082
mem 0000020c 45850010
mem 00000210 00000013
mem 00000300 02930001
mem 00000304 05130050
mem 00000308 80820070
mem 0000030c 00000013
test aligned 00000100 100 0 00000000 0
exp 00000100 00500093
exp 00000104 00a00113
exp 00000108 002081b3
exp 0000010c 40110233
test mixed 00000200 100 0 00000000 0
exp 00000200 00004501
exp 00000202 00000505
exp 00000204 00c58633
exp 00000208 00008082
exp 0000020a 00100113
exp 0000020e 00004585
exp 00000210 00000013
test unaligned 00000302 100 0 00000000 0
exp 00000302 00500293
exp 00000306 00700513
exp 0000030a 00008082
exp 0000030c 00000013
test branch 00000100 70 14 0000020a 0
exp 0000020a 00100113
exp 0000020e 00004585
exp 00000210 00000013
test backpressure 00000200 40 0 00000000 0
exp 00000200 00004501
exp 00000202 00000505
exp 00000204 00c58633
exp 00000208 00008082
exp 0000020a 00100113
exp 0000020e 00004585
exp 00000210 00000013
test disable 00000300 100 0 00000000 1
exp 00000300 00000001
exp 00000302 00500293
exp 00000306 00700513
exp 0000030a 00008082
